/* exec_pkg.sv */
package exec_pkg;

    // --------------------
    // widths
    // --------------------

    // data and address width, fixed by RV32I.
    parameter int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // funct7 values that OP and the immediate shifts accept.
    parameter logic [6:0] funct7_base = 7'b0000000;
    parameter logic [6:0] funct7_alt = 7'b0100000;

    // --------------------
    // encodings
    // --------------------

    // instruction bits 6:2.
    typedef enum logic [4:0] {
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } opcode_e;

    // mcause codes raised here, decode causes pass through raw.
    typedef enum logic [3:0] {
        CAUSE_MISALIGNED_FETCH = 4'd0,
        CAUSE_ILLEGAL_INSTR    = 4'd2
    } trap_cause_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } alu_funct_e;

    // 010 and 011 are not branch codes.
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_funct_e;

endpackage

/* exec_if.sv */
`timescale 1ns/1ps

// one decoded instruction, steered to a single unit.
interface exec_issue_if;
    logic int_valid;
    logic branch_valid;
    exec_pkg::opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    exec_pkg::word_t rs1_data;
    exec_pkg::word_t rs2_data;
    exec_pkg::word_t imm;
    exec_pkg::word_t pc;
    exec_pkg::word_t next_pc;

    modport dispatch (
        output int_valid, branch_valid, opcode, funct3, funct7,
        output rs1_data, rs2_data, imm, pc, next_pc
    );

    modport unit (
        input int_valid, branch_valid, opcode, funct3, funct7,
        input rs1_data, rs2_data, imm, pc, next_pc
    );
endinterface

// registered output of one execution unit.
interface unit_result_if;
    logic valid;
    logic exception;
    logic [3:0] trap_cause;
    exec_pkg::word_t result;

    modport unit (
        output valid, exception, trap_cause, result
    );

    modport select (
        input valid, exception, trap_cause, result
    );
endinterface

/* exec_dispatch.sv */
`timescale 1ns/1ps

module exec_dispatch (
    input  logic clk,
    input  logic rst,
    input  logic prev_stalled,
    input  logic decode_exception,
    input  logic [3:0] decode_trap_cause,
    input  logic decode_is_reg_write,
    input  exec_pkg::word_t decode_instruction_addr,
    input  exec_pkg::word_t decode_instruction_next_addr,
    input  exec_pkg::opcode_e opcode,
    input  logic [4:0] rd,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  exec_pkg::word_t decode_rs1_data,
    input  exec_pkg::word_t decode_rs2_data,
    input  logic [11:0] i_imm,
    input  logic [11:0] b_imm,
    input  logic [19:0] u_imm,
    input  logic [19:0] j_imm,
    input  logic exec_is_reg_write,
    input  logic [4:0] exec_reg_write_sel,
    input  exec_pkg::word_t exec_result,
    input  logic exec_pipeline_flush,
    exec_issue_if.dispatch issue,
    output logic tag_reg_write,
    output logic [4:0] tag_reg_sel,
    output logic tag_exception,
    output logic [3:0] tag_trap_cause,
    output exec_pkg::word_t exec_instruction_next_addr
);

    logic accept;
    logic is_int;
    logic is_branch;

    // decode reads the register file a cycle early, so our own last result
    // has to be forwarded here.
    assign issue.rs1_data = (exec_is_reg_write && exec_reg_write_sel == rs1) ?
                            exec_result : decode_rs1_data;
    assign issue.rs2_data = (exec_is_reg_write && exec_reg_write_sel == rs2) ?
                            exec_result : decode_rs2_data;

    assign accept = !prev_stalled && !exec_pipeline_flush;

    assign is_int = opcode inside {exec_pkg::OP, exec_pkg::OP_IMM, exec_pkg::LUI,
                                   exec_pkg::AUIPC};
    assign is_branch = opcode inside {exec_pkg::BRANCH, exec_pkg::JAL, exec_pkg::JALR};

    assign issue.int_valid = accept && !decode_exception && is_int;
    assign issue.branch_valid = accept && !decode_exception && is_branch;

    assign issue.opcode = opcode;
    assign issue.funct3 = funct3;
    assign issue.funct7 = funct7;
    assign issue.pc = decode_instruction_addr;
    assign issue.next_pc = decode_instruction_next_addr;

    // b and j immediates hold bits 12:1 and 20:1.
    always_comb begin
        case (opcode)
            exec_pkg::LUI, exec_pkg::AUIPC: issue.imm = {u_imm, 12'b0};
            exec_pkg::BRANCH: issue.imm = {{19{b_imm[11]}}, b_imm, 1'b0};
            exec_pkg::JAL:    issue.imm = {{11{j_imm[19]}}, j_imm, 1'b0};
            default:          issue.imm = {{20{i_imm[11]}}, i_imm};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_reg_write <= 1'b0;
            tag_exception <= 1'b0;
        end else begin
            tag_reg_write <= accept && decode_is_reg_write && rd != 5'd0;
            tag_exception <= accept && (decode_exception || !(is_int || is_branch));
        end
    end

    always_ff @(posedge clk) begin
        tag_reg_sel <= rd;
        tag_trap_cause <= decode_exception ? decode_trap_cause :
                          exec_pkg::CAUSE_ILLEGAL_INSTR;
        exec_instruction_next_addr <= decode_instruction_next_addr;
    end

    assert property (@(posedge clk) disable iff (rst)
        !(issue.int_valid && issue.branch_valid));

endmodule

/* exec_int.sv */
`timescale 1ns/1ps

module exec_int (
    input  logic clk,
    input  logic rst,
    exec_issue_if.unit issue,
    unit_result_if.unit res
);

    logic is_op;
    logic alt;
    logic funct7_used;
    logic funct7_illegal;
    logic [4:0] shamt;
    exec_pkg::word_t op_b;
    exec_pkg::word_t alu_out;
    exec_pkg::word_t int_out;

    assign is_op = issue.opcode == exec_pkg::OP;
    assign op_b = is_op ? issue.rs2_data : issue.imm;
    assign shamt = op_b[4:0];
    assign alt = issue.funct7 == exec_pkg::funct7_alt;

    // for OP-IMM, funct7 only exists on the shifts.
    assign funct7_used = is_op ||
                         (issue.opcode == exec_pkg::OP_IMM &&
                          (issue.funct3 == exec_pkg::SLL || issue.funct3 == exec_pkg::SRL_SRA));
    assign funct7_illegal = funct7_used && issue.funct7 != exec_pkg::funct7_base &&
                            issue.funct7 != exec_pkg::funct7_alt;

    always_comb begin
        case (exec_pkg::alu_funct_e'(issue.funct3))
            exec_pkg::ADD_SUB: alu_out = (is_op && alt) ? issue.rs1_data - op_b :
                                                          issue.rs1_data + op_b;
            exec_pkg::SLL:     alu_out = issue.rs1_data << shamt;
            exec_pkg::SLT:     alu_out = {{(exec_pkg::xlen-1){1'b0}},
                                          $signed(issue.rs1_data) < $signed(op_b)};
            exec_pkg::SLTU:    alu_out = {{(exec_pkg::xlen-1){1'b0}}, issue.rs1_data < op_b};
            exec_pkg::XOR:     alu_out = issue.rs1_data ^ op_b;
            exec_pkg::SRL_SRA: alu_out = alt ? $signed(issue.rs1_data) >>> shamt :
                                               issue.rs1_data >> shamt;
            exec_pkg::OR:      alu_out = issue.rs1_data | op_b;
            default:           alu_out = issue.rs1_data & op_b;
        endcase
    end

    always_comb begin
        case (issue.opcode)
            exec_pkg::LUI:   int_out = issue.imm;
            exec_pkg::AUIPC: int_out = issue.pc + issue.imm;
            default:         int_out = alu_out;
        endcase
    end

    // --------------------
    // output register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
            res.exception <= 1'b0;
        end else begin
            res.valid <= issue.int_valid;
            res.exception <= issue.int_valid && funct7_illegal;
        end
    end

    always_ff @(posedge clk) begin
        res.result <= int_out;
        res.trap_cause <= exec_pkg::CAUSE_ILLEGAL_INSTR;
    end

endmodule

/* exec_branch.sv */
`timescale 1ns/1ps

module exec_branch (
    input  logic clk,
    input  logic rst,
    exec_issue_if.unit issue,
    unit_result_if.unit res,
    output logic taken,
    output exec_pkg::word_t target
);

    logic cmp;
    logic is_jump;
    logic will_take;
    logic misaligned;
    exec_pkg::word_t jalr_sum;
    exec_pkg::word_t next_target;

    always_comb begin
        case (exec_pkg::br_funct_e'(issue.funct3))
            exec_pkg::BEQ:  cmp = issue.rs1_data == issue.rs2_data;
            exec_pkg::BNE:  cmp = issue.rs1_data != issue.rs2_data;
            exec_pkg::BLT:  cmp = $signed(issue.rs1_data) < $signed(issue.rs2_data);
            exec_pkg::BGE:  cmp = $signed(issue.rs1_data) >= $signed(issue.rs2_data);
            exec_pkg::BLTU: cmp = issue.rs1_data < issue.rs2_data;
            exec_pkg::BGEU: cmp = issue.rs1_data >= issue.rs2_data;
            default:        cmp = 1'b0;
        endcase
    end

    assign is_jump = issue.opcode == exec_pkg::JAL || issue.opcode == exec_pkg::JALR;
    assign will_take = is_jump || (issue.opcode == exec_pkg::BRANCH && cmp);

    // jalr drops bit 0 of the sum.
    assign jalr_sum = issue.rs1_data + issue.imm;
    assign next_target = (issue.opcode == exec_pkg::JALR) ?
                         {jalr_sum[exec_pkg::xlen-1:1], 1'b0} :
                         issue.pc + issue.imm;

    // no compressed instructions, so targets must be word aligned.
    assign misaligned = will_take && next_target[1];

    // --------------------
    // output register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
            res.exception <= 1'b0;
            taken <= 1'b0;
        end else begin
            res.valid <= issue.branch_valid;
            res.exception <= issue.branch_valid && misaligned;
            taken <= issue.branch_valid && will_take && !misaligned;
        end
    end

    // link value, ignored for conditional branches.
    always_ff @(posedge clk) begin
        res.result <= issue.next_pc;
        res.trap_cause <= exec_pkg::CAUSE_MISALIGNED_FETCH;
        target <= next_target;
    end

    assert property (@(posedge clk) disable iff (rst)
        taken |-> target[0] == 1'b0);

endmodule

/* exec_result_select.sv */
`timescale 1ns/1ps

module exec_result_select (
    unit_result_if.select int_res,
    unit_result_if.select br_res,
    input  logic br_taken,
    input  exec_pkg::word_t br_target,
    input  logic tag_reg_write,
    input  logic [4:0] tag_reg_sel,
    input  logic tag_exception,
    input  logic [3:0] tag_trap_cause,
    output logic stall_next,
    output logic exec_exception,
    output logic [3:0] exec_trap_cause,
    output logic exec_is_taken_branch,
    output exec_pkg::word_t exec_branch_target,
    output logic exec_is_reg_write,
    output logic [4:0] exec_reg_write_sel,
    output exec_pkg::word_t exec_result,
    output logic exec_pipeline_flush
);

    logic unit_valid;

    assign unit_valid = int_res.valid || br_res.valid;

    // without a unit result, only a buffered exception can be reported.
    always_comb begin
        case ({br_res.valid, int_res.valid})
            2'b10: begin
                exec_exception = br_res.exception;
                exec_trap_cause = br_res.trap_cause;
                exec_result = br_res.result;
            end
            2'b01: begin
                exec_exception = int_res.exception;
                exec_trap_cause = int_res.trap_cause;
                exec_result = int_res.result;
            end
            default: begin
                exec_exception = tag_exception;
                exec_trap_cause = tag_trap_cause;
                exec_result = '0;
            end
        endcase
    end

    assign stall_next = !unit_valid && !tag_exception;

    assign exec_is_taken_branch = br_res.valid && br_taken;
    assign exec_branch_target = br_target;

    assign exec_is_reg_write = tag_reg_write && unit_valid && !exec_exception;
    assign exec_reg_write_sel = tag_reg_sel;

    // decode predicts fall-through, so any taken branch is a mispredict.
    assign exec_pipeline_flush = exec_is_taken_branch || exec_exception;

    always_comb begin
        assert final (!(int_res.valid && br_res.valid));
    end

endmodule

/* exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
    input  logic clk,
    input  logic rst,
    input  logic prev_stalled,
    output logic stall_next,

    input  logic decode_exception,
    input  logic [3:0] decode_trap_cause,
    input  logic decode_is_reg_write,
    input  exec_pkg::word_t decode_instruction_addr,
    input  exec_pkg::word_t decode_instruction_next_addr,
    input  exec_pkg::opcode_e opcode,
    input  logic [4:0] rd,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  exec_pkg::word_t decode_rs1_data,
    input  exec_pkg::word_t decode_rs2_data,
    input  logic [11:0] i_imm,
    input  logic [11:0] b_imm,
    input  logic [19:0] u_imm,
    input  logic [19:0] j_imm,

    output logic exec_exception,
    output logic [3:0] exec_trap_cause,
    output logic exec_is_taken_branch,
    output exec_pkg::word_t exec_branch_target,
    output logic exec_is_reg_write,
    output logic [4:0] exec_reg_write_sel,
    output exec_pkg::word_t exec_result,
    output exec_pkg::word_t exec_instruction_next_addr,
    output logic exec_pipeline_flush
);

    logic tag_reg_write;
    logic [4:0] tag_reg_sel;
    logic tag_exception;
    logic [3:0] tag_trap_cause;
    logic br_taken;
    exec_pkg::word_t br_target;

    exec_issue_if issue();
    unit_result_if int_res();
    unit_result_if br_res();

    exec_dispatch exec_dispatch_i (.*);

    exec_int exec_int_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .res(int_res)
    );

    exec_branch exec_branch_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .res(br_res),
        .taken(br_taken),
        .target(br_target)
    );

    exec_result_select exec_result_select_i (.*);

endmodule

/* tb_exec_stage.sv */
`timescale 1ns/1ps

module tb_exec_stage;

    localparam int reps = 4;
    // alu, bypass, branch and exception instructions, three cycles each at most.
    localparam int instr_count = (2 * 8 * reps + 2 * reps) + 16 + 16 + 4;
    localparam int timeout_cycles = 16 + 3 * instr_count + 100;

    logic clk;
    logic rst;
    logic prev_stalled;
    logic stall_next;
    logic decode_exception;
    logic [3:0] decode_trap_cause;
    logic decode_is_reg_write;
    exec_pkg::word_t decode_instruction_addr;
    exec_pkg::word_t decode_instruction_next_addr;
    exec_pkg::opcode_e opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    exec_pkg::word_t decode_rs1_data;
    exec_pkg::word_t decode_rs2_data;
    logic [11:0] i_imm;
    logic [11:0] b_imm;
    logic [19:0] u_imm;
    logic [19:0] j_imm;
    logic exec_exception;
    logic [3:0] exec_trap_cause;
    logic exec_is_taken_branch;
    exec_pkg::word_t exec_branch_target;
    logic exec_is_reg_write;
    logic [4:0] exec_reg_write_sel;
    exec_pkg::word_t exec_result;
    exec_pkg::word_t exec_instruction_next_addr;
    logic exec_pipeline_flush;

    integer seed;
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int errors_before = 0;

    // expected response of the instruction in flight.
    logic exp_exc;
    logic [3:0] exp_cause;
    logic exp_wr;
    logic exp_taken;
    logic check_result;
    exec_pkg::word_t exp_result;
    exec_pkg::word_t exp_target;

    exec_stage exec_stage_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("simulation ran past %0d cycles without finishing", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // compare tasks
    // --------------------

    task automatic compare_word(input string what, input exec_pkg::word_t got,
                                input exec_pkg::word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_cause(input string what, input logic [3:0] got,
                                 input logic [3:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_sel(input string what, input logic [4:0] got,
                               input logic [4:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // --------------------
    // reference model
    // --------------------

    function automatic exec_pkg::word_t rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic exec_pkg::word_t alu_model(input logic is_op, input logic [2:0] f3,
                                                  input logic [6:0] f7,
                                                  input exec_pkg::word_t a,
                                                  input exec_pkg::word_t b);
        case (f3)
            3'b000: alu_model = (is_op && f7[5]) ? a - b : a + b;
            3'b001: alu_model = a << b[4:0];
            3'b010: alu_model = ($signed(a) < $signed(b)) ? 1 : 0;
            3'b011: alu_model = (a < b) ? 1 : 0;
            3'b100: alu_model = a ^ b;
            3'b101: begin
                if (f7[5])
                    alu_model = $signed(a) >>> b[4:0];
                else
                    alu_model = a >> b[4:0];
            end
            3'b110: alu_model = a | b;
            default: alu_model = a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input exec_pkg::word_t a,
                                         input exec_pkg::word_t b);
        case (f3)
            3'b000: branch_cond = a == b;
            3'b001: branch_cond = a != b;
            3'b100: branch_cond = $signed(a) < $signed(b);
            3'b101: branch_cond = $signed(a) >= $signed(b);
            3'b110: branch_cond = a < b;
            3'b111: branch_cond = a >= b;
            default: branch_cond = 1'b0;
        endcase
    endfunction

    // a and b are the operand values after any forwarding.
    task automatic predict(input exec_pkg::word_t a, input exec_pkg::word_t b);
        exec_pkg::word_t i_ext;
        exec_pkg::word_t target;
        logic cond;
        logic is_br;
        i_ext = {{20{i_imm[11]}}, i_imm};
        target = '0;
        cond = 1'b0;
        is_br = 1'b0;
        exp_exc = 1'b0;
        exp_cause = 4'd0;
        exp_taken = 1'b0;
        exp_result = '0;
        exp_target = '0;
        check_result = 1'b0;
        case (opcode)
            exec_pkg::OP, exec_pkg::OP_IMM: begin
                if ((opcode == exec_pkg::OP || funct3 == 3'b001 || funct3 == 3'b101) &&
                    funct7 != 7'h00 && funct7 != 7'h20) begin
                    exp_exc = 1'b1;
                    exp_cause = exec_pkg::CAUSE_ILLEGAL_INSTR;
                end else begin
                    exp_result = alu_model(opcode == exec_pkg::OP, funct3, funct7, a,
                                           (opcode == exec_pkg::OP) ? b : i_ext);
                    check_result = 1'b1;
                end
            end
            exec_pkg::LUI, exec_pkg::AUIPC: begin
                exp_result = {u_imm, 12'b0};
                if (opcode == exec_pkg::AUIPC)
                    exp_result = exp_result + decode_instruction_addr;
                check_result = 1'b1;
            end
            exec_pkg::BRANCH: begin
                is_br = 1'b1;
                cond = branch_cond(funct3, a, b);
                target = decode_instruction_addr + {{19{b_imm[11]}}, b_imm, 1'b0};
            end
            exec_pkg::JAL: begin
                is_br = 1'b1;
                cond = 1'b1;
                target = decode_instruction_addr + {{11{j_imm[19]}}, j_imm, 1'b0};
            end
            exec_pkg::JALR: begin
                is_br = 1'b1;
                cond = 1'b1;
                target = (a + i_ext) & ~32'd1;
            end
            default: begin
                exp_exc = 1'b1;
                exp_cause = exec_pkg::CAUSE_ILLEGAL_INSTR;
            end
        endcase
        if (is_br && cond && target[1]) begin
            exp_exc = 1'b1;
            exp_cause = exec_pkg::CAUSE_MISALIGNED_FETCH;
        end else if (is_br) begin
            exp_taken = cond;
            exp_target = target;
            if (opcode != exec_pkg::BRANCH) begin
                exp_result = decode_instruction_next_addr;
                check_result = 1'b1;
            end
        end
        if (decode_exception) begin
            exp_exc = 1'b1;
            exp_cause = decode_trap_cause;
            exp_taken = 1'b0;
            check_result = 1'b0;
        end
        exp_wr = decode_is_reg_write && rd != 5'd0 && !exp_exc;
    endtask

    // --------------------
    // drive and check
    // --------------------

    task automatic random_instr(input exec_pkg::opcode_e opc, input logic [2:0] f3);
        opcode = opc;
        funct3 = f3;
        funct7 = 7'h00;
        rd = 5'(rand_word());
        rs1 = 5'(rand_word());
        rs2 = 5'(rand_word());
        decode_rs1_data = rand_word();
        decode_rs2_data = rand_word();
        i_imm = 12'(rand_word());
        b_imm = 12'(rand_word()) & 12'hffe;
        u_imm = 20'(rand_word());
        j_imm = 20'(rand_word()) & 20'hffffe;
        decode_instruction_addr = rand_word() & 32'hffff_fffc;
        decode_instruction_next_addr = decode_instruction_addr + 32'd4;
        decode_is_reg_write = 1'b1;
        decode_exception = 1'b0;
        decode_trap_cause = 4'd0;
    endtask

    // presents the instruction and waits for the stage to report it.
    task automatic issue_and_wait;
        int n;
        n = 0;
        prev_stalled = 1'b0;
        @(posedge clk);
        @(negedge clk);
        while (stall_next && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (stall_next) begin
            error_count++;
            $display("no result from the DUT within %0d cycles at %0t ns", n + 1, $time);
        end
    endtask

    task automatic check_outputs;
        compare_bit("exec_exception", exec_exception, exp_exc);
        if (exp_exc)
            compare_cause("exec_trap_cause", exec_trap_cause, exp_cause);
        compare_bit("exec_is_reg_write", exec_is_reg_write, exp_wr);
        if (exp_wr)
            compare_sel("exec_reg_write_sel", exec_reg_write_sel, rd);
        compare_bit("exec_is_taken_branch", exec_is_taken_branch, exp_taken);
        compare_bit("exec_pipeline_flush", exec_pipeline_flush, exp_taken || exp_exc);
        if (check_result)
            compare_word("exec_result", exec_result, exp_result);
        if (exp_taken)
            compare_word("exec_branch_target", exec_branch_target, exp_target);
        compare_word("exec_instruction_next_addr", exec_instruction_next_addr,
                     decode_instruction_next_addr);
    endtask

    task automatic go_idle;
        prev_stalled = 1'b1;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_one;
        predict(decode_rs1_data, decode_rs2_data);
        issue_and_wait;
        check_outputs;
        go_idle;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("%s: %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    // --------------------
    // tests
    // --------------------

    // outputs still hold what the last edge under reset loaded.
    task automatic reset_and_idle;
        compare_bit("exec_exception", exec_exception, 1'b0);
        compare_bit("exec_is_reg_write", exec_is_reg_write, 1'b0);
        compare_bit("exec_is_taken_branch", exec_is_taken_branch, 1'b0);
        compare_bit("exec_pipeline_flush", exec_pipeline_flush, 1'b0);
        compare_bit("stall_next", stall_next, 1'b1);
        @(posedge clk);
        @(negedge clk);
        compare_bit("stall_next while stalled", stall_next, 1'b1);
        compare_bit("exec_is_reg_write while stalled", exec_is_reg_write, 1'b0);
        report_test("reset and idle");
    endtask

    task automatic alu_results;
        for (int i = 0; i < reps; i++) begin
            for (int f = 0; f < 8; f++) begin
                random_instr(exec_pkg::OP, 3'(f));
                funct7 = rand_word() & 1 ? 7'h20 : 7'h00;
                run_one;
                random_instr(exec_pkg::OP_IMM, 3'(f));
                // immediate shifts carry funct7 in the upper immediate bits.
                if (f == 1 || f == 5) begin
                    funct7 = (f == 5 && rand_word() & 1) ? 7'h20 : 7'h00;
                    i_imm[11:5] = funct7;
                end
                run_one;
            end
            random_instr(exec_pkg::LUI, 3'b000);
            // x0 as destination never writes.
            if (i == 0)
                rd = 5'd0;
            run_one;
            random_instr(exec_pkg::AUIPC, 3'b000);
            run_one;
        end
        report_test("alu results");
    endtask

    task automatic bypass_chain;
        exec_pkg::word_t prev;
        logic [4:0] dep;
        for (int i = 0; i < 8; i++) begin
            random_instr(exec_pkg::OP, 3'b000);
            rd = 5'(i + 1);
            predict(decode_rs1_data, decode_rs2_data);
            issue_and_wait;
            check_outputs;
            prev = exp_result;
            dep = rd;
            // the dependent instruction follows with no gap.
            random_instr(exec_pkg::OP, 3'(i));
            rs1 = (i % 2 == 0) ? dep : dep ^ 5'h10;
            rs2 = (i % 2 == 0) ? dep ^ 5'h10 : dep;
            predict((i % 2 == 0) ? prev : decode_rs1_data,
                    (i % 2 == 0) ? decode_rs2_data : prev);
            issue_and_wait;
            check_outputs;
            go_idle;
        end
        report_test("bypass");
    endtask

    task automatic branches_and_jumps;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            for (int k = 0; k < 2; k++) begin
                random_instr(exec_pkg::BRANCH, 3'(f));
                decode_is_reg_write = 1'b0;
                if (k == 1)
                    decode_rs2_data = decode_rs1_data;
                run_one;
            end
        end
        random_instr(exec_pkg::JAL, 3'b000);
        run_one;
        random_instr(exec_pkg::JALR, 3'b000);
        decode_rs1_data = decode_rs1_data & 32'hffff_fffc;
        i_imm = (i_imm & 12'hffc) | 12'h001;
        run_one;
        // an instruction offered during the flush cycle is dropped.
        random_instr(exec_pkg::JAL, 3'b000);
        predict(decode_rs1_data, decode_rs2_data);
        issue_and_wait;
        check_outputs;
        random_instr(exec_pkg::OP, 3'b000);
        rd = 5'd7;
        @(posedge clk);
        @(negedge clk);
        compare_bit("stall_next after flush", stall_next, 1'b1);
        compare_bit("exec_is_reg_write after flush", exec_is_reg_write, 1'b0);
        compare_bit("exec_exception after flush", exec_exception, 1'b0);
        go_idle;
        report_test("branches and jumps");
    endtask

    task automatic exception_cases;
        random_instr(exec_pkg::OP, 3'b000);
        decode_exception = 1'b1;
        decode_trap_cause = 4'hb;
        run_one;
        random_instr(exec_pkg::JAL, 3'b000);
        j_imm = 20'd1;
        run_one;
        // a load opcode.
        random_instr(exec_pkg::opcode_e'(5'b00000), 3'b010);
        run_one;
        random_instr(exec_pkg::OP, 3'b000);
        funct7 = 7'h01;
        run_one;
        report_test("exceptions");
    endtask

    initial begin
        seed = 32'h13b62283;
        clk = 1'b0;
        rst = 1'b1;
        // an instruction is offered while rst is high and must not show up.
        prev_stalled = 1'b0;
        random_instr(exec_pkg::OP, 3'b000);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        prev_stalled = 1'b1;
        reset_and_idle;
        alu_results;
        bypass_chain;
        branches_and_jumps;
        exception_cases;
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* exec_stage.f */
exec_pkg.sv
exec_if.sv
exec_dispatch.sv
exec_int.sv
exec_branch.sv
exec_result_select.sv
exec_stage.sv
tb_exec_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_exec_stage -f exec_stage.f -o sim_exec_stage
output=$(./obj_dir/sim_exec_stage)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
